// File: compile.f
design/iir_pkg.sv
design/iir_dispatch.sv
design/iir_biquad.sv
design/iir_collect.sv
design/iir_bank.sv
sim/iir_bank_sva.sv
sim/iir_checker.sv
sim/tb_iir_bank.sv

// File: design/iir_bank.sv
// Top of the four-channel IIR filter bank
// Host words in on one req/ack link, filtered samples out on the other
`timescale 1ns/1ps
`default_nettype none

module iir_bank (
    input  logic                              reset,
    input  logic                              clk,
    input  logic                              in_req,
    input  logic [iir_pkg::WORD_W-1:0]        in_word,
    output logic                              in_ack,
    output logic                              out_req,
    output logic [iir_pkg::CH_W-1:0]          out_chan,
    output logic signed [iir_pkg::DATA_W-1:0] out_sample,
    input  logic                              out_ack
);

    logic [iir_pkg::NUM_CH-1:0]        busy;
    logic [iir_pkg::NUM_CH-1:0]        coef_we;
    logic [iir_pkg::NUM_CH-1:0]        start;
    logic [iir_pkg::NUM_CH-1:0]        result_valid;
    logic [iir_pkg::NUM_CH-1:0]        take;
    logic [iir_pkg::COEF_IDX_W-1:0]    coef_idx;
    logic signed [iir_pkg::DATA_W-1:0] coef_data;
    logic signed [iir_pkg::DATA_W-1:0] sample_data;
    logic signed [iir_pkg::DATA_W-1:0] result_data [iir_pkg::NUM_CH];

    iir_dispatch dispatch_i (
        .reset       (reset),
        .clk         (clk),
        .in_req      (in_req),
        .in_word     (in_word),
        .in_ack      (in_ack),
        .busy        (busy),
        .coef_we     (coef_we),
        .coef_idx    (coef_idx),
        .coef_data   (coef_data),
        .start       (start),
        .sample_data (sample_data)
    );

    // --------------------
    // Channels share the write and sample buses
    for (genvar k = 0; k < iir_pkg::NUM_CH; k++) begin : g_ch
        iir_biquad biquad_i (
            .reset        (reset),
            .clk          (clk),
            .coef_we      (coef_we[k]),
            .coef_idx     (coef_idx),
            .coef_data    (coef_data),
            .start        (start[k]),
            .sample_data  (sample_data),
            .busy         (busy[k]),
            .result_valid (result_valid[k]),
            .result_data  (result_data[k]),
            .take         (take[k])
        );
    end

    iir_collect collect_i (
        .reset        (reset),
        .clk          (clk),
        .result_valid (result_valid),
        .result_data  (result_data),
        .take         (take),
        .out_req      (out_req),
        .out_chan     (out_chan),
        .out_sample   (out_sample),
        .out_ack      (out_ack)
    );

endmodule

`default_nettype wire

// File: design/iir_biquad.sv
// One biquad channel, time-multiplexed over a single multiply-accumulate
// Start loads a sample, result_valid rises 8 cycles later and holds until take
`timescale 1ns/1ps
`default_nettype none

module iir_biquad (
    input  logic                              reset,
    input  logic                              clk,
    input  logic                              coef_we,
    input  logic [iir_pkg::COEF_IDX_W-1:0]    coef_idx,
    input  logic signed [iir_pkg::DATA_W-1:0] coef_data,
    input  logic                              start,
    input  logic signed [iir_pkg::DATA_W-1:0] sample_data,
    output logic                              busy,
    output logic                              result_valid,
    output logic signed [iir_pkg::DATA_W-1:0] result_data,
    input  logic                              take
);

    logic [iir_pkg::STATE_W-1:0]    state;
    logic [iir_pkg::COEF_IDX_W-1:0] sel;
    logic                           sel_last;
    logic                           wait_cnt;
    logic                           mul_vld;
    logic                           mul_first;
    logic signed [iir_pkg::DATA_W-1:0] coefs [iir_pkg::NUM_COEF];
    logic signed [iir_pkg::DATA_W-1:0] xy    [iir_pkg::NUM_COEF];
    logic signed [iir_pkg::ACC_W-1:0]  mul_r;
    logic signed [iir_pkg::ACC_W-1:0]  acc_r;
    logic signed [iir_pkg::ACC_W-1:0]  acc_base;
    logic signed [iir_pkg::DATA_W-1:0] y_new;

    assign sel_last = (sel == iir_pkg::COEF_IDX_W'(iir_pkg::COEF_A2));
    assign acc_base = mul_first ? {iir_pkg::ACC_W{1'b0}} : acc_r;
    assign y_new    = acc_r[iir_pkg::FRAC_W +: iir_pkg::DATA_W];   // Bits 33:16, wraps

    // --------------------
    // Control FSM
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state    <= iir_pkg::BQ_IDLE;
            sel      <= '0;
            wait_cnt <= 1'b0;
        end else begin
            case (state)
                iir_pkg::BQ_IDLE: begin
                    if (start) begin
                        state <= iir_pkg::BQ_CALC;
                    end
                end
                iir_pkg::BQ_CALC: begin
                    if (sel_last) begin
                        sel   <= '0;
                        state <= iir_pkg::BQ_WAIT;
                    end else begin
                        sel <= sel + 1'b1;
                    end
                end
                iir_pkg::BQ_WAIT: begin
                    wait_cnt <= ~wait_cnt;             // Two drain cycles
                    if (wait_cnt) begin
                        state <= iir_pkg::BQ_DONE;
                    end
                end
                default: state <= iir_pkg::BQ_IDLE;    // Write-back cycle
            endcase
        end
    end

    // Coefficients and taps, tap k pairs with coefficient k
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            for (int i = 0; i < iir_pkg::NUM_COEF; i++) begin
                coefs[i] <= '0;
                xy[i]    <= '0;
            end
        end else begin
            if (coef_we && coef_idx < iir_pkg::COEF_IDX_W'(iir_pkg::NUM_COEF)) begin
                coefs[coef_idx] <= coef_data;
            end
            if (start) begin
                xy[iir_pkg::COEF_B0] <= sample_data;
                xy[iir_pkg::COEF_B1] <= xy[iir_pkg::COEF_B0];
                xy[iir_pkg::COEF_B2] <= xy[iir_pkg::COEF_B1];
            end
            if (state == iir_pkg::BQ_DONE) begin
                xy[iir_pkg::COEF_A1] <= y_new;
                xy[iir_pkg::COEF_A2] <= xy[iir_pkg::COEF_A1];
            end
        end
    end

    // --------------------
    // MAC pipeline, product then accumulate
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            mul_vld   <= 1'b0;
            mul_first <= 1'b0;
        end else begin
            mul_vld   <= (state == iir_pkg::BQ_CALC);
            mul_first <= (state == iir_pkg::BQ_CALC) && (sel == '0);
        end
    end

    always_ff @(posedge reset) begin
        mul_r <= xy[sel] * coefs[sel];
        if (mul_vld) begin
            acc_r <= acc_base + mul_r;
        end
    end

    // Result handoff
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            busy         <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            if (start) begin
                busy <= 1'b1;
            end else if (take) begin
                busy <= 1'b0;
            end
            if (state == iir_pkg::BQ_WAIT && wait_cnt) begin
                result_valid <= 1'b1;                  // Accumulator final by now
            end else if (take) begin
                result_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge reset) begin
        if (state == iir_pkg::BQ_WAIT && wait_cnt) begin
            result_data <= y_new;
        end
    end

endmodule

`default_nettype wire

// File: design/iir_collect.sv
// Output side of the filter bank: round-robin pick over finished channels
// Drives each taken result out through a four-phase req/ack master
`timescale 1ns/1ps
`default_nettype none

module iir_collect (
    input  logic                              reset,
    input  logic                              clk,
    input  logic [iir_pkg::NUM_CH-1:0]        result_valid,
    input  logic signed [iir_pkg::DATA_W-1:0] result_data [iir_pkg::NUM_CH],
    output logic [iir_pkg::NUM_CH-1:0]        take,
    output logic                              out_req,
    output logic [iir_pkg::CH_W-1:0]          out_chan,
    output logic signed [iir_pkg::DATA_W-1:0] out_sample,
    input  logic                              out_ack
);

    logic [iir_pkg::STATE_W-1:0] state;
    logic [iir_pkg::CH_W-1:0]    last;
    logic [iir_pkg::CH_W-1:0]    pick;
    logic                        found;
    logic                        grab;

    // First valid channel after the last one served
    always_comb begin
        logic [iir_pkg::CH_W-1:0] cand;
        pick  = last;
        found = 1'b0;
        for (int i = 1; i <= iir_pkg::NUM_CH; i++) begin
            cand = last + iir_pkg::CH_W'(i);
            if (!found && result_valid[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    assign grab = (state == iir_pkg::COL_IDLE) && found;

    // --------------------
    // Output handshake
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state   <= iir_pkg::COL_IDLE;
            last    <= iir_pkg::CH_W'(iir_pkg::NUM_CH - 1);   // Channel 0 goes first
            take    <= '0;
            out_req <= 1'b0;
        end else begin
            take <= '0;
            case (state)
                iir_pkg::COL_IDLE: begin
                    if (found) begin
                        take    <= iir_pkg::NUM_CH'(1) << pick;
                        last    <= pick;
                        out_req <= 1'b1;
                        state   <= iir_pkg::COL_REQ;
                    end
                end
                iir_pkg::COL_REQ: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= iir_pkg::COL_ACK_LO;
                    end
                end
                default: begin
                    if (!out_ack) begin
                        state <= iir_pkg::COL_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge reset) begin
        if (grab) begin
            out_chan   <= pick;
            out_sample <= result_data[pick];
        end
    end

endmodule

`default_nettype wire

// File: design/iir_dispatch.sv
// Input side of the filter bank: four-phase req/ack slave for host words
// Decodes each word and fires one coefficient write or sample start per word
`timescale 1ns/1ps
`default_nettype none

module iir_dispatch (
    input  logic                              reset,
    input  logic                              clk,
    input  logic                              in_req,
    input  iir_pkg::host_word_u               in_word,
    output logic                              in_ack,
    input  logic [iir_pkg::NUM_CH-1:0]        busy,
    output logic [iir_pkg::NUM_CH-1:0]        coef_we,
    output logic [iir_pkg::COEF_IDX_W-1:0]    coef_idx,
    output logic signed [iir_pkg::DATA_W-1:0] coef_data,
    output logic [iir_pkg::NUM_CH-1:0]        start,
    output logic signed [iir_pkg::DATA_W-1:0] sample_data
);

    logic [iir_pkg::STATE_W-1:0] state;
    logic [iir_pkg::CH_W-1:0]    chan;
    logic [iir_pkg::NUM_CH-1:0]  chan_sel;
    logic                        issue;

    // Channel field sits at the same place in both views
    assign chan     = in_word.smp.chan;
    assign chan_sel = iir_pkg::NUM_CH'(1) << chan;
    assign issue    = (state == iir_pkg::DSP_ISSUE);

    // Shared buses come straight off the held word
    assign coef_idx    = in_word.coef.idx;
    assign coef_data   = in_word.coef.value;
    assign sample_data = in_word.smp.sample;

    // Exactly one strobe in the issue cycle
    assign coef_we = (issue && in_word.coef.kind == iir_pkg::KIND_COEF) ? chan_sel : '0;
    assign start   = (issue && in_word.smp.kind == iir_pkg::KIND_SAMPLE) ? chan_sel : '0;

    // --------------------
    // Handshake FSM
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state  <= iir_pkg::DSP_IDLE;
            in_ack <= 1'b0;
        end else begin
            case (state)
                iir_pkg::DSP_IDLE: begin
                    if (in_req && !busy[chan]) begin   // Hold off while channel works
                        state <= iir_pkg::DSP_ISSUE;
                    end
                end
                iir_pkg::DSP_ISSUE: begin
                    in_ack <= 1'b1;
                    state  <= iir_pkg::DSP_ACK_HI;
                end
                iir_pkg::DSP_ACK_HI: begin
                    if (!in_req) begin
                        in_ack <= 1'b0;
                        state  <= iir_pkg::DSP_WAIT_LO;
                    end
                end
                default: begin
                    // Ack low for one full cycle before the next word is sampled
                    state <= iir_pkg::DSP_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/iir_pkg.sv
// Widths, indices, FSM encodings and the host word layout for the IIR filter bank
// Every design and testbench file refers to these by scoped name
`default_nettype none

package iir_pkg;

    // --------------------
    // Datapath sizes
    localparam int NUM_CH     = 4;
    localparam int CH_W       = 2;
    localparam int DATA_W     = 18;   // Q2.16 samples and coefficients
    localparam int ACC_W      = 48;
    localparam int FRAC_W     = 16;
    localparam int WORD_W     = 24;

    // --------------------
    // Coefficient slots, same order as the delay line taps
    localparam int NUM_COEF   = 5;
    localparam int COEF_IDX_W = 3;
    localparam int COEF_B0    = 0;
    localparam int COEF_B1    = 1;
    localparam int COEF_B2    = 2;
    localparam int COEF_A1    = 3;   // Feedback terms carry their own sign
    localparam int COEF_A2    = 4;

    localparam logic KIND_SAMPLE = 1'b0;
    localparam logic KIND_COEF   = 1'b1;

    // --------------------
    // FSM encodings
    localparam int STATE_W = 2;

    localparam logic [STATE_W-1:0] DSP_IDLE    = 2'd0;
    localparam logic [STATE_W-1:0] DSP_ISSUE   = 2'd1;
    localparam logic [STATE_W-1:0] DSP_ACK_HI  = 2'd2;
    localparam logic [STATE_W-1:0] DSP_WAIT_LO = 2'd3;

    localparam logic [STATE_W-1:0] BQ_IDLE     = 2'd0;
    localparam logic [STATE_W-1:0] BQ_CALC     = 2'd1;
    localparam logic [STATE_W-1:0] BQ_WAIT     = 2'd2;
    localparam logic [STATE_W-1:0] BQ_DONE     = 2'd3;

    localparam logic [STATE_W-1:0] COL_IDLE    = 2'd0;
    localparam logic [STATE_W-1:0] COL_REQ     = 2'd1;
    localparam logic [STATE_W-1:0] COL_ACK_LO  = 2'd2;

    // Host word, kind bit on top in both views
    typedef union packed {
        struct packed {
            logic                  kind;
            logic [CH_W-1:0]       chan;
            logic [COEF_IDX_W-1:0] pad;
            logic [DATA_W-1:0]     sample;
        } smp;
        struct packed {
            logic                  kind;
            logic [CH_W-1:0]       chan;
            logic [COEF_IDX_W-1:0] idx;
            logic [DATA_W-1:0]     value;
        } coef;
    } host_word_u;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the IIR filter bank testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=sim_iir_bank
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_iir_bank -f compile.f \
    --Mdir "$BUILD_DIR" -o "$SIM_EXE"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_EXE" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "Failure found in $LOG"
    exit 1
fi

echo "No failure found in $LOG"
exit 0

// File: sim/iir_bank_sva.sv
// Handshake assertions for both req/ack links of the filter bank
// Bound into every iir_bank instance
`timescale 1ns/1ps
`default_nettype none

module iir_bank_sva (
    input logic                              reset,
    input logic                              clk,
    input logic                              in_req,
    input logic                              in_ack,
    input logic                              out_req,
    input logic [iir_pkg::CH_W-1:0]          out_chan,
    input logic signed [iir_pkg::DATA_W-1:0] out_sample,
    input logic                              out_ack
);

    int fail_count = 0;   // Count of failed assertions

    // --------------------
    // Input link
    // Ack is set on the edge after req is seen, so req is checked one cycle back
    ack_needs_req: assert property (@(posedge reset) disable iff (clk)
        $rose(in_ack) |-> $past(in_req))
        else begin
            $error("in_ack rose without in_req high in the cycle before");
            fail_count++;
        end

    req_after_ack_low: assert property (@(posedge reset) disable iff (clk)
        $rose(in_req) |-> !in_ack)
        else begin
            $error("in_req rose while in_ack was still high");
            fail_count++;
        end

    // Output link holds request and payload until ack
    out_req_held: assert property (@(posedge reset) disable iff (clk)
        out_req && !out_ack |=> out_req && $stable(out_chan) && $stable(out_sample))
        else begin
            $error("out_req or its payload changed before out_ack");
            fail_count++;
        end

endmodule

bind iir_bank iir_bank_sva sva_i (
    .reset      (reset),
    .clk        (clk),
    .in_req     (in_req),
    .in_ack     (in_ack),
    .out_req    (out_req),
    .out_chan   (out_chan),
    .out_sample (out_sample),
    .out_ack    (out_ack)
);

`default_nettype wire

// File: sim/iir_checker.sv
// Checker for the filter bank output link
// Holds expected results per channel and compares every completed transfer
`timescale 1ns/1ps
`default_nettype none

module iir_checker (
    input  logic                       reset,
    input  logic                       clk,
    input  logic                       exp_push,
    input  logic [iir_pkg::CH_W-1:0]   exp_chan,
    input  logic [iir_pkg::DATA_W-1:0] exp_value,
    input  logic                       end_check,
    input  logic                       out_req,
    input  logic [iir_pkg::CH_W-1:0]   out_chan,
    input  logic [iir_pkg::DATA_W-1:0] out_sample,
    input  logic                       out_ack,
    output int                         errors,
    output int                         pending
);

    logic [iir_pkg::DATA_W-1:0] exp_q [iir_pkg::NUM_CH][$];
    int err_cnt = 0;
    int pend_cnt = 0;

    assign errors  = err_cnt;
    assign pending = pend_cnt;

    // One transfer completes on the edge where req and ack are both high
    task automatic compare_output(input logic [iir_pkg::CH_W-1:0] ch,
                                  input logic [iir_pkg::DATA_W-1:0] value);
        logic [iir_pkg::DATA_W-1:0] expected;
        if (exp_q[ch].size() == 0) begin
            $display("Unexpected output on channel %0d with no sample pending", ch);
            err_cnt++;
        end else begin
            expected = exp_q[ch].pop_front();
            pend_cnt--;
            if (value !== expected) begin
                $display("FAILED out_sample ch %0d: got %05h expected %05h", ch, value, expected);
                err_cnt++;
            end
        end
    endtask

    always @(posedge reset) begin
        if (!clk) begin
            if (exp_push) begin
                exp_q[exp_chan].push_back(exp_value);
                pend_cnt++;
            end
            if (out_req && out_ack) begin
                compare_output(out_chan, out_sample);
            end
            if (end_check) begin
                for (int ch = 0; ch < iir_pkg::NUM_CH; ch++) begin
                    if (exp_q[ch].size() != 0) begin
                        $display("Channel %0d never produced %0d expected outputs",
                                 ch, exp_q[ch].size());
                        err_cnt += exp_q[ch].size();
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/iir_vectors.txt
# C channel coef_index value        (coefficient write, Q2.16 in hex)
# S channel sample expected_output  (sample and the output it must give, Q2.16 in hex)
C 0 0 10000
C 0 3 08000
C 1 0 08000
C 1 1 08000
C 2 0 30000
C 2 4 3C000
C 3 0 1FFFF
S 0 10000 10000
S 1 10000 08000
S 2 08000 38000
S 3 1FFFF 3FFFC
S 0 00000 08000
S 1 04000 0A000
S 2 00000 00000
S 3 20000 00002
S 0 00000 04000
S 2 00000 02000
S 3 3FFFF 3FFFE
S 0 00000 02000

// File: sim/tb_iir_bank.sv
// Testbench for the IIR filter bank, run as the simulation top
// Streams host words from the vector file and answers the output link with random delays
`timescale 1ns/1ps
`default_nettype none

module tb_iir_bank;

    localparam string VEC_FILE        = "sim/iir_vectors.txt";
    localparam int    CYCLES_PER_LINE = 64;
    localparam int    EXTRA_CYCLES    = 200;

    logic                              reset;   // Clock
    logic                              clk;     // Reset, active high
    logic                              in_req;
    logic [iir_pkg::WORD_W-1:0]        in_word;
    logic                              in_ack;
    logic                              out_req;
    logic [iir_pkg::CH_W-1:0]          out_chan;
    logic signed [iir_pkg::DATA_W-1:0] out_sample;
    logic                              out_ack;
    logic                              exp_push;
    logic [iir_pkg::CH_W-1:0]          exp_chan;
    logic [iir_pkg::DATA_W-1:0]        exp_value;
    logic                              end_check;
    int                                check_errors;
    int                                pending;

    string       vec_lines [$];
    int          tb_errors = 0;
    int          timeouts = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    logic [31:0] rng_state = 32'd15;

    iir_bank dut_i (
        .reset      (reset),
        .clk        (clk),
        .in_req     (in_req),
        .in_word    (in_word),
        .in_ack     (in_ack),
        .out_req    (out_req),
        .out_chan   (out_chan),
        .out_sample (out_sample),
        .out_ack    (out_ack)
    );

    iir_checker check_i (
        .reset      (reset),
        .clk        (clk),
        .exp_push   (exp_push),
        .exp_chan   (exp_chan),
        .exp_value  (exp_value),
        .end_check  (end_check),
        .out_req    (out_req),
        .out_chan   (out_chan),
        .out_sample (out_sample),
        .out_ack    (out_ack),
        .errors     (check_errors),
        .pending    (pending)
    );

    always #2 reset = ~reset;   // 4 ns period

    always @(posedge reset) cycles <= cycles + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // --------------------
    // Stimulus helpers, all driving on the falling edge
    task automatic read_vectors();
        int    fd;
        string line;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VEC_FILE);
            tb_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 2 && (line[0] == "C" || line[0] == "S")) begin
                vec_lines.push_back(line);   // Comment and blank lines dropped
            end
        end
        $fclose(fd);
    endtask

    task automatic send_word(input logic [iir_pkg::WORD_W-1:0] word);
        @(negedge reset);
        in_word = word;
        in_req  = 1'b1;
        while (!in_ack) @(negedge reset);
        in_req = 1'b0;
        while (in_ack) @(negedge reset);
    endtask

    task automatic push_expected(input logic [iir_pkg::CH_W-1:0] ch,
                                 input logic [iir_pkg::DATA_W-1:0] value);
        @(negedge reset);
        exp_chan  = ch;
        exp_value = value;
        exp_push  = 1'b1;
        @(negedge reset);
        exp_push = 1'b0;
    endtask

    task automatic apply_line(input string line);
        logic [31:0]         f_chan;
        logic [31:0]         f_mid;
        logic [31:0]         f_last;
        iir_pkg::host_word_u word;
        int                  n;
        word = '0;
        n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", f_chan, f_mid, f_last);
        if (n != 3) begin
            $display("Vector line has %0d fields instead of 3: %s", n, line);
            tb_errors++;
        end else if (line[0] == "C") begin
            word.coef.kind  = iir_pkg::KIND_COEF;
            word.coef.chan  = f_chan[iir_pkg::CH_W-1:0];
            word.coef.idx   = f_mid[iir_pkg::COEF_IDX_W-1:0];
            word.coef.value = f_last[iir_pkg::DATA_W-1:0];
            send_word(word);
        end else begin
            word.smp.kind   = iir_pkg::KIND_SAMPLE;
            word.smp.chan   = f_chan[iir_pkg::CH_W-1:0];
            word.smp.sample = f_mid[iir_pkg::DATA_W-1:0];
            push_expected(f_chan[iir_pkg::CH_W-1:0], f_last[iir_pkg::DATA_W-1:0]);
            send_word(word);
        end
    endtask

    task automatic end_run();
        int total;
        @(negedge reset);
        end_check = 1'b1;   // Checker lists channels still owed outputs
        @(negedge reset);
        end_check = 1'b0;
        total = tb_errors + check_errors + dut_i.sva_i.fail_count;
        $display("Errors: %0d  Timeouts: %0d", total, timeouts);
        if (total == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    // --------------------
    // Output ack with a random 0 to 7 cycle delay
    initial begin
        int delay;
        forever begin
            @(negedge reset);
            if (out_req && !out_ack) begin
                rng_state = xorshift32(rng_state);
                delay     = int'(rng_state % 32'd8);
                repeat (delay) @(negedge reset);
                out_ack = 1'b1;
                while (out_req) @(negedge reset);
                out_ack = 1'b0;
            end
        end
    end

    initial begin
        wait (cycle_limit > 0);
        wait (cycles >= cycle_limit);
        timeouts = 1;
        $display("Timeout after %0d cycles with %0d outputs still missing", cycles, pending);
        end_run();
    end

    initial begin
        reset     = 1'b0;
        clk       = 1'b1;
        in_req    = 1'b0;
        in_word   = '0;
        out_ack   = 1'b0;
        exp_push  = 1'b0;
        exp_chan  = '0;
        exp_value = '0;
        end_check = 1'b0;
        read_vectors();
        cycle_limit = vec_lines.size() * CYCLES_PER_LINE + EXTRA_CYCLES;
        repeat (4) @(posedge reset);
        @(negedge reset);
        clk = 1'b0;
        foreach (vec_lines[i]) begin
            apply_line(vec_lines[i]);
        end
        while (pending != 0) @(negedge reset);
        repeat (20) @(negedge reset);   // Room for any extra output to show up
        end_run();
    end

endmodule

`default_nettype wire
